// File: src/plic_pkg.sv
/* shared widths, register map offsets, enums and packed structs
   for the interrupt controller and its testbench */

`default_nettype none

package plic_pkg;

  localparam int PRIO_W = 3;   // priority and threshold
  localparam int ID_W   = 5;   // source id, up to 32 sources
  localparam int CTX_W  = 3;   // context index, up to 8 contexts
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // byte address map
  localparam logic [ADDR_W-1:0] OFS_PRIO    = 16'h0000;  // 4*n per source
  localparam logic [ADDR_W-1:0] OFS_PENDING = 16'h1000;  // single word
  localparam logic [ADDR_W-1:0] OFS_ENABLE  = 16'h2000;  // 0x80*c per context
  localparam logic [ADDR_W-1:0] OFS_CONTEXT = 16'h8000;  // 0x1000*c, thresh +0, claim +4

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } ctrl_state_e;

  typedef enum logic [2:0] {
    REG_PRIO,
    REG_PENDING,
    REG_ENABLE,
    REG_THRESH,
    REG_CLAIM,
    REG_NONE
  } reg_kind_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;   // unmapped address
  } reg_rsp_t;

  typedef struct packed {
    logic              en;
    reg_kind_e         kind;
    logic [CTX_W-1:0]  ctx;
    logic [ID_W-1:0]   idx;
    logic [DATA_W-1:0] data;
  } cfg_wr_t;

  typedef struct packed {
    logic            claim;
    logic            complete;
    logic [ID_W-1:0] id;
  } gate_op_t;

endpackage

`default_nettype wire

// File: src/plic_cfg_regs.sv
/* configuration storage: source priorities, context enables
   and context thresholds */

`timescale 1ns/1ps
`default_nettype none

module plic_cfg_regs #(
  parameter int SRC_NUM = 32,
  parameter int CTX_NUM = 2
) (
  input  logic                                     clk,
  input  logic                                     nrst,
  input  plic_pkg::cfg_wr_t                        i_cfg_wr,
  output logic [SRC_NUM-1:0][plic_pkg::PRIO_W-1:0] o_prio,
  output logic [CTX_NUM-1:0][SRC_NUM-1:0]          o_enable,
  output logic [CTX_NUM-1:0][plic_pkg::PRIO_W-1:0] o_thresh
);

  import plic_pkg::*;

  logic wr_prio;
  logic wr_enable;
  logic wr_thresh;

  assign wr_prio   = i_cfg_wr.en && (i_cfg_wr.kind == REG_PRIO);
  assign wr_enable = i_cfg_wr.en && (i_cfg_wr.kind == REG_ENABLE);
  assign wr_thresh = i_cfg_wr.en && (i_cfg_wr.kind == REG_THRESH);

  // source priorities, entry 0 stays zero
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_prio <= '0;
    end else begin
      for (int n = 1; n < SRC_NUM; n++) begin
        if (wr_prio && i_cfg_wr.idx == n) begin
          o_prio[n] <= i_cfg_wr.data[PRIO_W-1:0];
        end
      end
    end
  end

  // per context enable word and threshold
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_enable <= '0;
      o_thresh <= '0;
    end else begin
      for (int c = 0; c < CTX_NUM; c++) begin
        if (i_cfg_wr.ctx == c) begin
          if (wr_enable) o_enable[c] <= i_cfg_wr.data[SRC_NUM-1:0];
          if (wr_thresh) o_thresh[c] <= i_cfg_wr.data[PRIO_W-1:0];
        end
      end
    end
  end

  // the bus controller filters source 0 before it gets here
  a_no_prio0_wr: assert property (@(posedge clk) disable iff (!nrst)
    wr_prio |-> i_cfg_wr.idx != '0);

endmodule

`default_nettype wire

// File: src/plic_gateway.sv
/* level gateways: per-source pending and claimed bits,
   closed from claim until complete */

`timescale 1ns/1ps
`default_nettype none

module plic_gateway #(
  parameter int SRC_NUM = 32
) (
  input  logic                                     clk,
  input  logic                                     nrst,
  input  logic [SRC_NUM-1:0]                       i_irq,
  input  logic [SRC_NUM-1:0][plic_pkg::PRIO_W-1:0] i_prio,
  input  plic_pkg::gate_op_t                       i_gate_op,
  output logic [SRC_NUM-1:0]                       o_pending
);

  import plic_pkg::*;

  logic [SRC_NUM-1:0] claimed_q;  // gate closed while set

  // source 0 is reserved, its bits only see reset
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_pending <= '0;
      claimed_q <= '0;
    end else begin
      for (int n = 1; n < SRC_NUM; n++) begin
        if (i_gate_op.claim && i_gate_op.id == n) begin
          o_pending[n] <= 1'b0;
          claimed_q[n] <= 1'b1;
        end else begin
          if (i_gate_op.complete && i_gate_op.id == n) begin
            claimed_q[n] <= 1'b0;  // reopens, may pend next cycle
          end
          if (i_irq[n] && i_prio[n] != '0 && !claimed_q[n]) begin
            o_pending[n] <= 1'b1;
          end
        end
      end
    end
  end

  // claim id comes from the arbiter via the bus controller
  a_claim_pending: assert property (@(posedge clk) disable iff (!nrst)
    i_gate_op.claim |-> (i_gate_op.id < SRC_NUM) && o_pending[i_gate_op.id]);

endmodule

`default_nettype wire

// File: src/plic_target_arb.sv
/* per-context arbiter: highest priority pending source above
   the threshold, registered best id and interrupt line */

`timescale 1ns/1ps
`default_nettype none

module plic_target_arb #(
  parameter int SRC_NUM = 32,
  parameter int CTX_NUM = 2
) (
  input  logic                                     clk,
  input  logic                                     nrst,
  input  logic [SRC_NUM-1:0]                       i_pending,
  input  logic [SRC_NUM-1:0][plic_pkg::PRIO_W-1:0] i_prio,
  input  logic [CTX_NUM-1:0][SRC_NUM-1:0]          i_enable,
  input  logic [CTX_NUM-1:0][plic_pkg::PRIO_W-1:0] i_thresh,
  output logic [CTX_NUM-1:0][plic_pkg::ID_W-1:0]   o_best_id,
  output logic [CTX_NUM-1:0]                       o_ip
);

  import plic_pkg::*;

  logic [CTX_NUM-1:0][ID_W-1:0] best_id_d;

  always_comb begin : arb_comb
    logic [PRIO_W-1:0] best_prio;
    best_prio = '0;
    for (int c = 0; c < CTX_NUM; c++) begin
      best_id_d[c] = '0;
      best_prio    = i_thresh[c];  // strictly above threshold to win
      // ascending scan, strict compare keeps the lowest id on ties
      for (int n = 1; n < SRC_NUM; n++) begin
        if (i_pending[n] && i_enable[c][n] && i_prio[n] > best_prio) begin
          best_id_d[c] = ID_W'(n);
          best_prio    = i_prio[n];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_best_id <= '0;
      o_ip      <= '0;
    end else begin
      o_best_id <= best_id_d;
      for (int c = 0; c < CTX_NUM; c++) begin
        o_ip[c] <= |best_id_d[c];
      end
    end
  end

  // with config steady, a raised line always points above threshold
  for (genvar c = 0; c < CTX_NUM; c++) begin : g_chk
    a_ip_prio: assert property (@(posedge clk) disable iff (!nrst)
      o_ip[c] && $stable(i_prio) && $stable(i_thresh)
      |-> i_prio[o_best_id[c]] > i_thresh[c]);
  end

endmodule

`default_nettype wire

// File: src/plic_bus_ctrl.sv
/* register bus controller: address decode, config writes,
   claim/complete pulses and registered read response */

`timescale 1ns/1ps
`default_nettype none

module plic_bus_ctrl #(
  parameter int SRC_NUM = 32,
  parameter int CTX_NUM = 2
) (
  input  logic                                          clk,
  input  logic                                          nrst,
  input  logic                                          i_req_valid,
  output logic                                          o_req_ready,
  input  plic_pkg::reg_req_t                            i_req,
  output logic                                          o_rsp_valid,
  input  logic                                          i_rsp_ready,
  output plic_pkg::reg_rsp_t                            o_rsp,
  input  logic [SRC_NUM-1:0][plic_pkg::PRIO_W-1:0]      i_prio,
  input  logic [CTX_NUM-1:0][SRC_NUM-1:0]               i_enable,
  input  logic [CTX_NUM-1:0][plic_pkg::PRIO_W-1:0]      i_thresh,
  input  logic [SRC_NUM-1:0]                            i_pending,
  input  logic [CTX_NUM-1:0][plic_pkg::ID_W-1:0]        i_best_id,
  output plic_pkg::cfg_wr_t                             o_cfg_wr,
  output plic_pkg::gate_op_t                            o_gate_op
);

  import plic_pkg::*;

  ctrl_state_e      state_q, state_d;
  reg_kind_e        kind;
  logic [ID_W-1:0]  src_idx;
  logic [CTX_W-1:0] ctx_idx;
  logic             accept;
  logic             wr_ok;
  reg_rsp_t         rsp_d;

  assign o_req_ready = (state_q == ST_IDLE);
  assign o_rsp_valid = (state_q == ST_RESP);
  assign accept      = i_req_valid & o_req_ready;

  // address decode with index range checks
  always_comb begin
    kind    = REG_NONE;
    src_idx = '0;
    ctx_idx = '0;
    if (i_req.addr[1:0] == 2'b00) begin  // word aligned only
      if (i_req.addr[15:12] == OFS_PRIO[15:12]) begin
        src_idx = i_req.addr[2 +: ID_W];
        if (i_req.addr[11:2] < SRC_NUM) kind = REG_PRIO;
      end else if (i_req.addr == OFS_PENDING) begin
        kind = REG_PENDING;
      end else if (i_req.addr[15:12] == OFS_ENABLE[15:12] && i_req.addr[6:0] == 7'h00) begin
        ctx_idx = i_req.addr[7 +: CTX_W];
        if (i_req.addr[11:7] < CTX_NUM) kind = REG_ENABLE;
      end else if (i_req.addr[15] == OFS_CONTEXT[15]) begin
        ctx_idx = i_req.addr[12 +: CTX_W];
        if (ctx_idx < CTX_NUM) begin
          if (i_req.addr[11:0] == 12'h000) kind = REG_THRESH;
          else if (i_req.addr[11:0] == 12'h004) kind = REG_CLAIM;
        end
      end
    end
  end

  // pending word is read only, source 0 priority is fixed
  assign wr_ok = (kind == REG_PRIO && src_idx != '0) ||
                 (kind == REG_ENABLE) || (kind == REG_THRESH);

  always_comb begin
    o_cfg_wr.en   = accept & i_req.we & wr_ok;
    o_cfg_wr.kind = kind;
    o_cfg_wr.ctx  = ctx_idx;
    o_cfg_wr.idx  = src_idx;
    o_cfg_wr.data = i_req.wdata;
  end

  always_comb begin
    o_gate_op.claim    = accept & ~i_req.we & (kind == REG_CLAIM) & (|i_best_id[ctx_idx]);
    o_gate_op.complete = accept & i_req.we & (kind == REG_CLAIM);
    o_gate_op.id       = i_req.we ? i_req.wdata[ID_W-1:0] : i_best_id[ctx_idx];
  end

  // read data, captured at acceptance
  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.err   = (kind == REG_NONE);
    if (!i_req.we) begin
      case (kind)
        REG_PRIO:    rsp_d.rdata = DATA_W'(i_prio[src_idx]);
        REG_PENDING: rsp_d.rdata = DATA_W'(i_pending);
        REG_ENABLE:  rsp_d.rdata = DATA_W'(i_enable[ctx_idx]);
        REG_THRESH:  rsp_d.rdata = DATA_W'(i_thresh[ctx_idx]);
        REG_CLAIM:   rsp_d.rdata = DATA_W'(i_best_id[ctx_idx]);  // 0 when nothing qualifies
        default:     rsp_d.rdata = '0;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (i_req_valid) state_d = ST_RESP;
      ST_RESP: if (i_rsp_ready) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state_q <= ST_IDLE;
      o_rsp   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) o_rsp <= rsp_d;  // held until the response transfer
    end
  end

  // response must not change while stalled
  a_rsp_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

`default_nettype wire

// File: src/plic_top.sv
/* interrupt controller top: bus controller, config registers,
   gateways and per-context arbiters */

`timescale 1ns/1ps
`default_nettype none

module plic_top #(
  parameter int SRC_NUM = 32,  // includes reserved source 0
  parameter int CTX_NUM = 2
) (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_req_valid,
  output logic               o_req_ready,
  input  plic_pkg::reg_req_t i_req,
  output logic               o_rsp_valid,
  input  logic               i_rsp_ready,
  output plic_pkg::reg_rsp_t o_rsp,
  input  logic [SRC_NUM-1:0] i_irq,
  output logic [CTX_NUM-1:0] o_ip
);

  import plic_pkg::*;

  cfg_wr_t                      cfg_wr;
  gate_op_t                     gate_op;
  logic [SRC_NUM-1:0][PRIO_W-1:0] prio;
  logic [CTX_NUM-1:0][SRC_NUM-1:0] enable;
  logic [CTX_NUM-1:0][PRIO_W-1:0] thresh;
  logic [SRC_NUM-1:0]           pending;
  logic [CTX_NUM-1:0][ID_W-1:0] best_id;

  plic_bus_ctrl #(.SRC_NUM(SRC_NUM), .CTX_NUM(CTX_NUM)) i_bus_ctrl (
    .clk         (clk),
    .nrst        (nrst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp),
    .i_prio      (prio),
    .i_enable    (enable),
    .i_thresh    (thresh),
    .i_pending   (pending),
    .i_best_id   (best_id),
    .o_cfg_wr    (cfg_wr),
    .o_gate_op   (gate_op)
  );

  plic_cfg_regs #(.SRC_NUM(SRC_NUM), .CTX_NUM(CTX_NUM)) i_cfg_regs (
    .clk      (clk),
    .nrst     (nrst),
    .i_cfg_wr (cfg_wr),
    .o_prio   (prio),
    .o_enable (enable),
    .o_thresh (thresh)
  );

  plic_gateway #(.SRC_NUM(SRC_NUM)) i_gateway (
    .clk       (clk),
    .nrst      (nrst),
    .i_irq     (i_irq),
    .i_prio    (prio),
    .i_gate_op (gate_op),
    .o_pending (pending)
  );

  plic_target_arb #(.SRC_NUM(SRC_NUM), .CTX_NUM(CTX_NUM)) i_target_arb (
    .clk       (clk),
    .nrst      (nrst),
    .i_pending (pending),
    .i_prio    (prio),
    .i_enable  (enable),
    .i_thresh  (thresh),
    .o_best_id (best_id),
    .o_ip      (o_ip)
  );

endmodule

`default_nettype wire

// File: verification/tb_plic.sv
/* interrupt controller testbench with bus tasks, a reference
   arbitration model, concurrent checks and six directed and random tests */

`timescale 1ns/1ps
`default_nettype none

module tb_plic;

  import plic_pkg::*;

  localparam int TIMEOUT = 200;  // cycles per wait loop

  logic clk, nrst, i_req_valid, o_req_ready, o_rsp_valid, i_rsp_ready;
  reg_req_t    i_req;
  reg_rsp_t    o_rsp;
  logic [31:0] i_irq;
  logic [1:0]  o_ip;

  logic [2:0]  prio_m [32];  // reference copies of the register state
  logic [31:0] en_m [2];
  logic [2:0]  thr_m [2];
  logic [31:0] pend_m;
  int errors = 0, tests_failed = 0, ops_cnt = 0, req_hs = 0, rsp_hs = 0;
  logic lat_en = 1'b0;
  int   lat_src = 1, lat_ctx = 0;
  logic lat_irq, lat_ip;

  plic_top i_plic_top (
    .clk(clk), .nrst(nrst), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
    .i_req(i_req), .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready),
    .o_rsp(o_rsp), .i_irq(i_irq), .o_ip(o_ip)
  );

  always #20 clk = ~clk;

  assign lat_irq = i_irq[lat_src];
  assign lat_ip  = o_ip[lat_ctx];

  always @(posedge clk) begin
    if (nrst && i_req_valid && o_req_ready) req_hs++;
    if (nrst && o_rsp_valid && i_rsp_ready) rsp_hs++;
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
    i_req_valid && !o_req_ready |=> i_req_valid && $stable(i_req))
    else begin errors++; $display("request changed while stalled at %0t", $time); end
  a_rsp_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else begin errors++; $display("response changed while stalled at %0t", $time); end
  a_one_at_a_time: assert property (@(posedge clk) disable iff (!nrst)
    o_rsp_valid |-> !o_req_ready)
    else begin errors++; $display("request ready during response at %0t", $time); end
  // irq rise seen at edge k gives o_ip at k+2 and not before
  a_ip_latency: assert property (@(posedge clk) disable iff (!nrst)
    lat_en && $past(lat_irq, 2) && !$past(lat_irq, 3) |-> lat_ip && !$past(lat_ip))
    else begin errors++; $display("o_ip latency is not 2 cycles at %0t", $time); end

  task automatic abort_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic bus_xfer(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int cnt;
    int hold;
    @(negedge clk);
    i_req.we    = we;
    i_req.addr  = addr;
    i_req.wdata = wdata;
    i_req_valid = 1'b1;
    cnt = 0;
    while (!o_req_ready) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("request never accepted");
    end
    @(negedge clk);  // accepted on the edge just passed
    i_req_valid = 1'b0;
    ops_cnt++;
    hold = ($urandom % 3 == 0) ? 1 + $urandom % 6 : 0;
    repeat (hold) @(negedge clk);  // response back-pressure
    i_rsp_ready = 1'b1;
    cnt = 0;
    while (!o_rsp_valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("response never arrived");
    end
    rdata = o_rsp.rdata;
    err   = o_rsp.err;
    @(negedge clk);
    i_rsp_ready = 1'b0;
  endtask

  // a read waits behind a held write response and goes once it drains
  task automatic write_with_queued_read(input int n, input logic [2:0] p);
    int cnt;
    int hold;
    prio_m[n] = p;
    @(negedge clk);
    i_req.we    = 1'b1;
    i_req.addr  = 16'(4 * n);
    i_req.wdata = 32'(p);
    i_req_valid = 1'b1;
    cnt = 0;
    while (!o_req_ready) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("write never accepted");
    end
    @(negedge clk);
    i_req.we    = 1'b0;  // read of the same entry now waits
    i_req.wdata = '0;
    ops_cnt += 2;
    hold = 1 + $urandom % 6;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_val("o_req_ready", 32'(o_req_ready), 32'd0);
    end
    check_val("o_rsp.err", 32'(o_rsp.err), 32'd0);
    i_rsp_ready = 1'b1;
    cnt = 0;
    while (!o_req_ready) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("queued read never accepted");
    end
    @(negedge clk);
    i_req_valid = 1'b0;
    cnt = 0;
    while (!o_rsp_valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("read response never arrived");
    end
    check_val("o_rsp.err", 32'(o_rsp.err), 32'd0);
    check_val($sformatf("prio[%0d]", n), o_rsp.rdata, 32'(prio_m[n]));
    @(negedge clk);
    i_rsp_ready = 1'b0;
  endtask

  task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b1, addr, data, rd, err);
    check_val("o_rsp.err", 32'(err), 32'd0);
  endtask

  task automatic reg_check(input string name, input logic [15:0] addr,
                           input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b0, addr, '0, rd, err);
    check_val("o_rsp.err", 32'(err), 32'd0);
    check_val(name, rd, exp);
  endtask

  task automatic set_prio(input int n, input logic [2:0] p);
    prio_m[n] = p;
    reg_write(16'(4 * n), 32'(p));
  endtask

  task automatic set_ctx(input int c, input logic [31:0] en, input logic [2:0] thr);
    en_m[c]  = en;
    thr_m[c] = thr;
    reg_write(16'h2000 + 16'(c * 'h80), en);
    reg_write(16'h8000 + 16'(c * 'h1000), 32'(thr));
  endtask

  task automatic wait_ip(input int c, input logic level);
    int cnt;
    cnt = 0;
    while (o_ip[c] !== level) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run($sformatf("o_ip[%0d] never reached %0d", c, level));
    end
  endtask

  task automatic watch_ip_low(input int c, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_val($sformatf("o_ip[%0d]", c), 32'(o_ip[c]), 32'd0);
    end
  endtask

  // expected winner found by scanning priorities from the top
  function automatic int expected_winner(input int c);
    for (int p = 7; p > int'(thr_m[c]); p--) begin
      for (int n = 1; n < 32; n++) begin
        if (pend_m[n] && en_m[c][n] && prio_m[n] == p) return n;
      end
    end
    return 0;
  endfunction

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int e0;
    int n;
    logic [31:0] rd, pick;
    logic        err;
    void'($urandom(32'h19d3_fd90));
    clk = 1'b0;
    nrst = 1'b0;
    i_req_valid = 1'b0;
    i_req = '0;
    i_rsp_ready = 1'b0;
    i_irq = '0;
    for (int i = 0; i < 32; i++) prio_m[i] = '0;
    pend_m = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;

    e0 = errors;  // register read-back
    check_val("o_req_ready", 32'(o_req_ready), 32'd1);
    check_val("o_rsp_valid", 32'(o_rsp_valid), 32'd0);
    check_val("o_ip", 32'(o_ip), 32'd0);
    for (int i = 1; i < 32; i++) set_prio(i, 3'($urandom));
    for (int c = 0; c < 2; c++) set_ctx(c, $urandom & 32'hffff_fffe, 3'($urandom));
    for (int i = 1; i < 32; i++) reg_check($sformatf("prio[%0d]", i), 16'(4 * i), 32'(prio_m[i]));
    for (int c = 0; c < 2; c++) begin
      reg_check("enable", 16'h2000 + 16'(c * 'h80), en_m[c]);
      reg_check("threshold", 16'h8000 + 16'(c * 'h1000), 32'(thr_m[c]));
    end
    reg_write(16'h0000, 32'd5);
    reg_check("prio[0]", 16'h0000, 32'd0);
    bus_xfer(1'b0, 16'h4000, '0, rd, err);  // unmapped
    check_val("unmapped err", 32'(err), 32'd1);
    check_val("unmapped rdata", rd, 32'd0);
    report_test("register read-back", e0);

    e0 = errors;  // single interrupt
    set_prio(3, 3'd5);
    set_ctx(0, 32'h0000_0008, 3'd2);
    set_ctx(1, 32'h0, 3'd0);
    lat_src = 3;
    lat_ctx = 0;
    lat_en = 1'b1;
    @(negedge clk);
    i_irq[3] = 1'b1;
    wait_ip(0, 1'b1);
    reg_check("claim ctx0", 16'h8004, 32'd3);
    lat_en = 1'b0;
    reg_check("pending", 16'h1000, 32'd0);
    wait_ip(0, 1'b0);
    i_irq[3] = 1'b0;
    reg_write(16'h8004, 32'd3);  // complete
    report_test("single interrupt", e0);

    e0 = errors;  // arbitration among random sources
    for (int i = 1; i < 32; i++) set_prio(i, 3'(1 + $urandom % 7));
    set_ctx(0, 32'hffff_fffe, 3'd0);
    pick = ($urandom | $urandom) & 32'hffff_fffe;
    @(negedge clk);
    i_irq = pick;
    pend_m = pick;
    wait_ip(0, 1'b1);
    @(negedge clk);
    i_irq = '0;
    while (pend_m != '0) begin
      n = expected_winner(0);
      reg_check("claim ctx0", 16'h8004, 32'(n));
      pend_m[n] = 1'b0;
    end
    reg_check("claim ctx0 empty", 16'h8004, 32'd0);
    for (int i = 1; i < 32; i++) if (pick[i]) reg_write(16'h8004, 32'(i));
    report_test("arbitration", e0);

    e0 = errors;  // masking and isolation
    set_prio(5, 3'd2);
    set_prio(6, 3'd4);
    set_prio(7, 3'd6);
    set_ctx(0, 32'h0000_0060, 3'd4);  // 5 and 6 not above threshold
    set_ctx(1, 32'h0000_0080, 3'd0);
    @(negedge clk);
    i_irq[7:5] = 3'b111;
    watch_ip_low(0, 6);
    check_val("o_ip[1]", 32'(o_ip[1]), 32'd1);
    reg_check("claim ctx0", 16'h8004, 32'd0);
    reg_check("claim ctx1", 16'h9004, 32'd7);
    set_ctx(0, 32'h0000_0060, 3'd1);
    i_irq[7:5] = 3'b000;
    reg_check("claim ctx0", 16'h8004, 32'd6);
    reg_check("claim ctx0", 16'h8004, 32'd5);
    for (int i = 5; i < 8; i++) reg_write(16'h8004, 32'(i));
    report_test("masking and isolation", e0);

    e0 = errors;  // gateway holds until complete
    set_prio(9, 3'd3);
    set_ctx(0, 32'h0000_0200, 3'd0);
    @(negedge clk);
    i_irq[9] = 1'b1;
    wait_ip(0, 1'b1);
    reg_check("claim ctx0", 16'h8004, 32'd9);
    watch_ip_low(0, 6);
    reg_check("pending", 16'h1000, 32'd0);
    reg_write(16'h8004, 32'd9);
    wait_ip(0, 1'b1);
    reg_check("pending", 16'h1000, 32'h0000_0200);
    i_irq[9] = 1'b0;
    reg_check("claim ctx0", 16'h8004, 32'd9);
    reg_write(16'h8004, 32'd9);
    report_test("gateway", e0);

    e0 = errors;  // back-pressure with nothing lost or repeated
    for (int i = 0; i < 24; i++) begin
      n = 1 + $urandom % 31;
      if (i % 3 == 0) begin
        write_with_queued_read(n, 3'($urandom));
      end else begin
        set_prio(n, 3'($urandom));
        reg_check($sformatf("prio[%0d]", n), 16'(4 * n), 32'(prio_m[n]));
      end
    end
    check_val("request handshakes", 32'(req_hs), 32'(ops_cnt));
    check_val("response handshakes", 32'(rsp_hs), 32'(ops_cnt));
    report_test("back-pressure", e0);

    $display("tests run: 6, failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/plic_pkg.sv
src/plic_cfg_regs.sv
src/plic_gateway.sv
src/plic_target_arb.sv
src/plic_bus_ctrl.sv
src/plic_top.sv
verification/tb_plic.sv

// File: Makefile
# Verilator simulation of the interrupt controller testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_plic
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
